// ==== common/trig_if.sv ====
// one trigger descriptor moving between pipeline stages
interface trig_if ();
    import wfd_daq_pkg::*;

    logic       valid;      // push strobe or not-empty level, depending on the hop
    trig_num_t  trig_num;
    chan_mask_t chan_mask;
    evt_len_t   evt_len;
    logic       take;       // pop pulse from the consumer

    modport source (
        output valid,
        output trig_num,
        output chan_mask,
        output evt_len,
        input  take
    );

    modport sink (
        input  valid,
        input  trig_num,
        input  chan_mask,
        input  evt_len,
        output take
    );
endinterface

// ==== common/wfd_consts.svh ====
`ifndef WFD_CONSTS_SVH
`define WFD_CONSTS_SVH

// channel trigger lines, one per channel fpga
`define WFD_NUM_CHAN        5

// descriptor queue slots between trigger and builder
`define WFD_FIFO_DEPTH      4

// acq_trigs pulse length in clk125 cycles
`define WFD_TRIG_PULSE      4

// tag bytes in bits 63..56 of the framing words
`define WFD_HDR_TAG         8'hA5
`define WFD_TRL_TAG         8'h5A

// board id, ascii "WFD0"
`define WFD_ID_VALUE        32'h5746_4430

// user bus register map, word addresses
`define WFD_REG_CTRL        0   // bit 0 enable
`define WFD_REG_MASK        1   // channel mask
`define WFD_REG_LEN         2   // payload words per event
`define WFD_REG_TRIG        3   // write fires a trigger, reads 0
`define WFD_REG_TCOUNT      4   // accepted triggers, read only
`define WFD_REG_DROPS       5   // descriptors lost to a full queue
`define WFD_REG_ID          6   // read only board id

// payload word count field in the len register
`define WFD_LEN_BITS        16

// trigger number field, shared by header, trailer and counters
`define WFD_TRIG_BITS       24

`endif

// ==== common/wfd_daq_pkg.sv ====
`include "wfd_consts.svh"

// trigger and event side types
package wfd_daq_pkg;

    // running trigger number, also used for the status counters
    typedef logic [`WFD_TRIG_BITS-1:0] trig_num_t;

    // one bit per channel trigger line
    typedef logic [`WFD_NUM_CHAN-1:0] chan_mask_t;

    // payload words per event, excluding header and trailer
    typedef logic [`WFD_LEN_BITS-1:0] evt_len_t;

    // one word on the daq link
    typedef logic [63:0] daq_word_t;

    // event builder states
    typedef enum logic [1:0] {
        IDLE,       // waiting on a queued descriptor
        HEADER,     // tag, trigger number, length, mask
        PAYLOAD,    // test pattern words
        TRAILER     // tag, trigger number, word count
    } builder_state_t;

endpackage

// ==== common/wfd_ipb_pkg.sv ====
// user bus side types, the register map itself lives in wfd_consts.svh
package wfd_ipb_pkg;

    // 24 address bits reach the slave, upper byte is decoded above us
    typedef logic [23:0] ipb_addr_t;

    // bus data word, both directions
    typedef logic [31:0] ipb_data_t;

    // ctrl register layout
    typedef struct packed {
        logic [30:0] rsvd;      // reads back 0
        logic        enable;    // accept trigger commands
    } ctrl_reg_t;

endpackage

// ==== daq/event_builder.sv ====
`include "wfd_consts.svh"

module event_builder (
    input  logic                   clk125,
    input  logic                   rst_n,
    trig_if.sink                   trig_out,
    input  logic                   daq_ready,
    input  logic                   daq_almost_full,
    output logic                   daq_valid,
    output logic                   daq_header,
    output logic                   daq_trailer,
    output wfd_daq_pkg::daq_word_t daq_data
);
    import wfd_daq_pkg::*;

    builder_state_t state;
    trig_num_t      cur_num;    // descriptor of the event in progress
    chan_mask_t     cur_mask;
    evt_len_t       cur_len;
    evt_len_t       word_idx;   // payload word position k
    logic           link_ok;    // link can take a word this cycle
    logic           emit;

    assign link_ok = daq_ready && !daq_almost_full;
    assign emit    = link_ok && (state != IDLE);

    // pop the head as soon as we pick it up
    assign trig_out.take = (state == IDLE) && trig_out.valid;

    assign daq_valid   = emit;
    assign daq_header  = emit && (state == HEADER);
    assign daq_trailer = emit && (state == TRAILER);

    // word follows state and index, so a stall simply holds it
    always_comb begin
        case (state)
            HEADER: begin
                daq_data = {`WFD_HDR_TAG, cur_num, cur_len,
                            {(16 - `WFD_NUM_CHAN){1'b0}}, cur_mask};
            end
            PAYLOAD: begin
                daq_data = {8'h00, cur_num, 16'h0000, word_idx};  // test pattern
            end
            TRAILER: begin
                daq_data = {`WFD_TRL_TAG, cur_num, 32'(cur_len) + 32'd2};
            end
            default: daq_data = '0;
        endcase
    end

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            state    <= IDLE;
            word_idx <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (trig_out.valid) state <= HEADER;
                end
                HEADER: begin
                    if (link_ok) begin
                        word_idx <= '0;
                        state    <= (cur_len == '0) ? TRAILER : PAYLOAD;  // empty event
                    end
                end
                PAYLOAD: begin
                    if (link_ok) begin
                        word_idx <= word_idx + 1'b1;
                        if (word_idx == cur_len - 1'b1) state <= TRAILER;
                    end
                end
                TRAILER: begin
                    if (link_ok) state <= IDLE;
                end
                default: state <= IDLE;
            endcase
        end
    end

    // latch the head entry at pop time
    always_ff @(posedge clk125) begin
        if (trig_out.take) begin
            cur_num  <= trig_out.trig_num;
            cur_mask <= trig_out.chan_mask;
            cur_len  <= trig_out.evt_len;
        end
    end

    // flagged words go out valid and carry the matching tag byte
    a_flags_valid: assert property (@(posedge clk125) disable iff (!rst_n)
        (daq_header || daq_trailer) |-> daq_valid &&
            (daq_data[63:56] == (daq_header ? `WFD_HDR_TAG : `WFD_TRL_TAG)));

    // each header is closed by a trailer before the next header
    a_framing: assert property (@(posedge clk125) disable iff (!rst_n)
        daq_header |=> (!daq_header until_with daq_trailer));

endmodule

// ==== design/channel_triggers.sv ====
`include "wfd_consts.svh"

module channel_triggers (
    input  logic                     clk125,
    input  logic                     rst_n,
    input  logic                     trig_cmd,
    input  logic                     enable,
    input  wfd_daq_pkg::chan_mask_t  chan_mask,
    input  wfd_daq_pkg::evt_len_t    evt_len,
    output logic [`WFD_NUM_CHAN-1:0] acq_trigs,
    output wfd_daq_pkg::trig_num_t   trig_count,
    trig_if.source                   trig_in
);
    import wfd_daq_pkg::*;

    localparam int PW = $clog2(`WFD_TRIG_PULSE + 1);

    logic          accept;      // command arrived while enabled
    logic [PW-1:0] pulse_cnt;   // cycles left in the current pulse
    chan_mask_t    pulse_mask;  // mask of the trigger that owns the pulse

    assign accept    = trig_cmd && enable;
    assign acq_trigs = (pulse_cnt != '0) ? pulse_mask : '0;

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            trig_count    <= '0;
            trig_in.valid <= 1'b0;
            pulse_cnt     <= '0;
        end else begin
            trig_in.valid <= accept;   // push lands one cycle after the command
            if (accept) begin
                trig_count <= trig_count + 1'b1;
                pulse_cnt  <= PW'(`WFD_TRIG_PULSE);   // restart even mid pulse
            end else if (pulse_cnt != '0) begin
                pulse_cnt <= pulse_cnt - 1'b1;
            end
        end
    end

    // descriptor fields, numbered before the count moves on
    always_ff @(posedge clk125) begin
        if (accept) begin
            trig_in.trig_num  <= trig_count;
            trig_in.chan_mask <= chan_mask;
            trig_in.evt_len   <= evt_len;
            pulse_mask        <= chan_mask;
        end
    end

    // Once WFD_TRIG_PULSE cycles pass with no accepted trigger the lines
    // must all be back at zero.
    a_pulse_window: assert property (@(posedge clk125) disable iff (!rst_n)
        !accept [*`WFD_TRIG_PULSE] |=> (acq_trigs == '0));

endmodule

// ==== design/ipb_regs.sv ====
`include "wfd_consts.svh"

module ipb_regs (
    input  logic                    clk125,
    input  logic                    rst_n,
    input  logic                    ipb_strobe,
    input  wfd_ipb_pkg::ipb_addr_t  ipb_addr,
    input  logic                    ipb_write,
    input  wfd_ipb_pkg::ipb_data_t  ipb_wdata,
    input  wfd_daq_pkg::trig_num_t  trig_count,
    input  wfd_daq_pkg::trig_num_t  drop_count,
    output wfd_ipb_pkg::ipb_data_t  ipb_rdata,
    output logic                    ipb_ack,
    output logic                    trig_cmd,
    output logic                    enable,
    output wfd_daq_pkg::chan_mask_t chan_mask,
    output wfd_daq_pkg::evt_len_t   evt_len
);
    import wfd_ipb_pkg::*;

    ctrl_reg_t ctrl_q;
    logic      strobe_d;        // strobe as seen last cycle
    logic      start;           // first sampled cycle of an access
    logic      wr_en;
    ipb_data_t rd_mux;

    // master holds strobe until ack, so only the rising edge counts
    assign start  = ipb_strobe && !strobe_d;
    assign wr_en  = start && ipb_write;
    assign enable = ctrl_q.enable;

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            strobe_d  <= 1'b0;
            ipb_ack   <= 1'b0;
            trig_cmd  <= 1'b0;
            ctrl_q    <= '0;
            chan_mask <= '0;
            evt_len   <= '0;
        end else begin
            strobe_d <= ipb_strobe;
            ipb_ack  <= start;     // one ack per access, next cycle
            trig_cmd <= wr_en && (ipb_addr == ipb_addr_t'(`WFD_REG_TRIG));
            if (wr_en) begin
                case (ipb_addr)
                    ipb_addr_t'(`WFD_REG_CTRL): ctrl_q.enable <= ipb_wdata[0];
                    ipb_addr_t'(`WFD_REG_MASK): chan_mask <= ipb_wdata[`WFD_NUM_CHAN-1:0];
                    ipb_addr_t'(`WFD_REG_LEN):  evt_len <= ipb_wdata[`WFD_LEN_BITS-1:0];
                    default: ;  // trig handled above, status regs read only
                endcase
            end
        end
    end

    // read map, everything zero-extended
    always_comb begin
        case (ipb_addr)
            ipb_addr_t'(`WFD_REG_CTRL):   rd_mux = ctrl_q;
            ipb_addr_t'(`WFD_REG_MASK):   rd_mux = ipb_data_t'(chan_mask);
            ipb_addr_t'(`WFD_REG_LEN):    rd_mux = ipb_data_t'(evt_len);
            ipb_addr_t'(`WFD_REG_TCOUNT): rd_mux = ipb_data_t'(trig_count);
            ipb_addr_t'(`WFD_REG_DROPS):  rd_mux = ipb_data_t'(drop_count);
            ipb_addr_t'(`WFD_REG_ID):     rd_mux = `WFD_ID_VALUE;
            default:                      rd_mux = '0;  // trig reg and holes
        endcase
    end

    // captured with the ack so data and ack line up
    always_ff @(posedge clk125) begin
        if (start) begin
            ipb_rdata <= rd_mux;
        end
    end

    // the master must keep strobe up through the ack cycle
    a_ack_in_strobe: assert property (@(posedge clk125) disable iff (!rst_n)
        ipb_ack |-> ipb_strobe);

endmodule

// ==== design/trig_fifo.sv ====
`include "wfd_consts.svh"

module trig_fifo (
    input  logic                   clk125,
    input  logic                   rst_n,
    trig_if.sink                   trig_in,
    trig_if.source                 trig_out,
    output wfd_daq_pkg::trig_num_t drop_count
);
    import wfd_daq_pkg::*;

    localparam int AW = $clog2(`WFD_FIFO_DEPTH);
    localparam int CW = $clog2(`WFD_FIFO_DEPTH + 1);

    trig_num_t     num_mem  [`WFD_FIFO_DEPTH];
    chan_mask_t    mask_mem [`WFD_FIFO_DEPTH];
    evt_len_t      len_mem  [`WFD_FIFO_DEPTH];
    logic [AW-1:0] wr_ptr;
    logic [AW-1:0] rd_ptr;
    logic [CW-1:0] count;      // occupancy
    logic          full;
    logic          push;
    logic          pop;

    function automatic logic [AW-1:0] next_ptr(input logic [AW-1:0] p);
        return (p == AW'(`WFD_FIFO_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full = (count == CW'(`WFD_FIFO_DEPTH));
    assign push = trig_in.valid && !full;   // full means refused, even with a pop
    assign pop  = trig_out.take;

    assign trig_in.take = 1'b0;  // producer side is a bare push strobe

    // head of queue
    assign trig_out.valid     = (count != '0);
    assign trig_out.trig_num  = num_mem[rd_ptr];
    assign trig_out.chan_mask = mask_mem[rd_ptr];
    assign trig_out.evt_len   = len_mem[rd_ptr];

    always_ff @(posedge clk125) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            drop_count <= '0;
        end else begin
            if (push) wr_ptr <= next_ptr(wr_ptr);
            if (pop)  rd_ptr <= next_ptr(rd_ptr);
            if (trig_in.valid && full) begin
                drop_count <= drop_count + 1'b1;  // lost descriptor
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk125) begin
        if (push) begin
            num_mem[wr_ptr]  <= trig_in.trig_num;
            mask_mem[wr_ptr] <= trig_in.chan_mask;
            len_mem[wr_ptr]  <= trig_in.evt_len;
        end
    end

    // the builder only pops what it can see
    a_no_underflow: assert property (@(posedge clk125) disable iff (!rst_n)
        trig_out.take |-> trig_out.valid);

endmodule

// ==== design/wfd_core.sv ====
`include "wfd_consts.svh"

module wfd_core (
    input  logic                     clk125,
    input  logic                     rst_n,
    input  logic                     ipb_strobe,
    input  wfd_ipb_pkg::ipb_addr_t   ipb_addr,
    input  logic                     ipb_write,
    input  wfd_ipb_pkg::ipb_data_t   ipb_wdata,
    output wfd_ipb_pkg::ipb_data_t   ipb_rdata,
    output logic                     ipb_ack,
    output logic [`WFD_NUM_CHAN-1:0] acq_trigs,
    output logic                     daq_valid,
    output logic                     daq_header,
    output logic                     daq_trailer,
    output wfd_daq_pkg::daq_word_t   daq_data,
    input  logic                     daq_ready,
    input  logic                     daq_almost_full
);
    import wfd_daq_pkg::*;

    logic       trig_cmd;      // software trigger pulse
    logic       enable;
    chan_mask_t chan_mask;
    evt_len_t   evt_len;
    trig_num_t  trig_count;    // status back to the register slave
    trig_num_t  drop_count;

    trig_if trig_in ();        // trigger stage to queue
    trig_if trig_out ();       // queue head to builder

    ipb_regs i_regs (
        .clk125     (clk125),
        .rst_n      (rst_n),
        .ipb_strobe (ipb_strobe),
        .ipb_addr   (ipb_addr),
        .ipb_write  (ipb_write),
        .ipb_wdata  (ipb_wdata),
        .trig_count (trig_count),
        .drop_count (drop_count),
        .ipb_rdata  (ipb_rdata),
        .ipb_ack    (ipb_ack),
        .trig_cmd   (trig_cmd),
        .enable     (enable),
        .chan_mask  (chan_mask),
        .evt_len    (evt_len)
    );

    channel_triggers i_trigs (
        .clk125     (clk125),
        .rst_n      (rst_n),
        .trig_cmd   (trig_cmd),
        .enable     (enable),
        .chan_mask  (chan_mask),
        .evt_len    (evt_len),
        .acq_trigs  (acq_trigs),
        .trig_count (trig_count),
        .trig_in    (trig_in.source)
    );

    trig_fifo i_fifo (
        .clk125     (clk125),
        .rst_n      (rst_n),
        .trig_in    (trig_in.sink),
        .trig_out   (trig_out.source),
        .drop_count (drop_count)
    );

    event_builder i_builder (
        .clk125          (clk125),
        .rst_n           (rst_n),
        .trig_out        (trig_out.sink),
        .daq_ready       (daq_ready),
        .daq_almost_full (daq_almost_full),
        .daq_valid       (daq_valid),
        .daq_header      (daq_header),
        .daq_trailer     (daq_trailer),
        .daq_data        (daq_data)
    );

endmodule

// ==== filelist.f ====
+incdir+common
common/wfd_ipb_pkg.sv
common/wfd_daq_pkg.sv
common/trig_if.sv
design/ipb_regs.sv
design/channel_triggers.sv
design/trig_fifo.sv
daq/event_builder.sv
design/wfd_core.sv
verif/wfd_clkgen.sv
verif/wfd_tb.sv

// ==== verif/wfd_clkgen.sv ====
module wfd_clkgen (
    output logic clk125,
    output logic rst_n
);
    // 20 unit period
    initial begin
        clk125 = 1'b0;
        forever #10 clk125 = ~clk125;
    end

    // reset held for 16 rising edges, released on an edge
    initial begin
        rst_n = 1'b0;
        repeat (16) @(posedge clk125);
        rst_n <= 1'b1;
    end
endmodule

// ==== verif/wfd_tb.sv ====
`include "wfd_consts.svh"

module wfd_tb;
    typedef struct packed {
        logic [`WFD_TRIG_BITS-1:0] num;
        logic [`WFD_NUM_CHAN-1:0]  mask;
        logic [`WFD_LEN_BITS-1:0]  len;
    } evt_t;

    logic                     clk125;
    logic                     rst_n;
    logic                     ipb_strobe;
    logic [23:0]              ipb_addr;
    logic                     ipb_write;
    logic [31:0]              ipb_wdata;
    logic [31:0]              ipb_rdata;
    logic                     ipb_ack;
    logic [`WFD_NUM_CHAN-1:0] acq_trigs;
    logic                     daq_valid;
    logic                     daq_header;
    logic                     daq_trailer;
    logic [63:0]              daq_data;
    logic                     daq_ready;
    logic                     daq_almost_full;

    evt_t   exp_q[$];           // events still owed by the DUT, oldest first
    int     word_pos = 0;       // position inside the head event
    int     errors = 0;
    int     checks = 0;
    int     err_mark = 0;
    int     test_num = 1;
    int     ack_count = 0;
    int     access_count = 0;
    int     next_num = 0;       // number the next accepted trigger gets
    int     bp_mode = 0;        // 0 open link, 1 random stalls, 2 almost_full held
    integer seed = 32'h9b0ceeb9;

    wfd_clkgen i_clkgen (.clk125(clk125), .rst_n(rst_n));

    wfd_core i_dut (
        .clk125          (clk125),
        .rst_n           (rst_n),
        .ipb_strobe      (ipb_strobe),
        .ipb_addr        (ipb_addr),
        .ipb_write       (ipb_write),
        .ipb_wdata       (ipb_wdata),
        .ipb_rdata       (ipb_rdata),
        .ipb_ack         (ipb_ack),
        .acq_trigs       (acq_trigs),
        .daq_valid       (daq_valid),
        .daq_header      (daq_header),
        .daq_trailer     (daq_trailer),
        .daq_data        (daq_data),
        .daq_ready       (daq_ready),
        .daq_almost_full (daq_almost_full)
    );

    task automatic check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("FAILED %s: got 0x%0h expected 0x%0h", name, got, exp);
        end
    endtask

    // expected word pos of an event, header at 0 and trailer at len+1
    function automatic logic [63:0] expect_word(input evt_t e, input int pos);
        logic [63:0] w;
        w = '0;
        w[55:32] = e.num;                       // every word carries the trigger number
        if (pos == 0) begin
            w[63:56]             = `WFD_HDR_TAG;
            w[31:16]             = e.len;
            w[`WFD_NUM_CHAN-1:0] = e.mask;
        end else if (pos == e.len + 1) begin
            w[63:56] = `WFD_TRL_TAG;
            w[31:0]  = e.len + 2;               // total word count
        end else begin
            w[31:0] = pos - 1;                  // payload k = pos-1
        end
        return w;
    endfunction

    task automatic bus_rw(input logic wr, input logic [23:0] addr, input logic [31:0] wdata,
                          output logic [31:0] rdata);
        int n;
        n = 0;
        @(posedge clk125);
        ipb_strobe <= 1'b1;
        ipb_addr   <= addr;
        ipb_write  <= wr;
        ipb_wdata  <= wdata;
        access_count++;
        @(negedge clk125);
        while (!ipb_ack && n < 16) begin
            @(negedge clk125);
            n++;
        end
        if (!ipb_ack) begin
            errors++;
            $display("timeout: no ack for access to address 0x%0h", addr);
        end
        rdata = ipb_rdata;
        @(posedge clk125);
        ipb_strobe <= 1'b0;     // low again for at least one cycle
        ipb_write  <= 1'b0;
    endtask

    task automatic reg_write(input int addr, input logic [31:0] data);
        logic [31:0] d;
        bus_rw(1'b1, 24'(addr), data, d);
    endtask

    task automatic reg_expect(input int addr, input logic [31:0] exp);
        logic [31:0] d;
        bus_rw(1'b0, 24'(addr), 32'h0, d);
        check_val($sformatf("ipb_rdata @%0h", addr), d, exp);
    endtask

    // accepted moves the numbering on, queued means an event is owed
    task automatic fire_trigger(input logic [4:0] mask, input logic [15:0] len,
                                input bit accepted, input bit queued);
        evt_t e;
        reg_write(`WFD_REG_MASK, 32'(mask));
        reg_write(`WFD_REG_LEN, 32'(len));
        e.num  = next_num;
        e.mask = mask;
        e.len  = len;
        if (queued) exp_q.push_back(e);
        if (accepted) next_num++;
        reg_write(`WFD_REG_TRIG, 32'h1);
    endtask

    task automatic check_pulse(input logic [4:0] mask);
        for (int i = 0; i <= `WFD_TRIG_PULSE; i++) begin
            @(negedge clk125);
            check_val("acq_trigs", acq_trigs, (i < `WFD_TRIG_PULSE) ? mask : 5'h00);
        end
    endtask

    task automatic wait_drain(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            @(negedge clk125);
            n++;
        end
        if (exp_q.size() != 0) begin
            errors++;
            $display("timeout: %0d events never arrived on the DAQ link", exp_q.size());
        end
    endtask

    task automatic report_test(input string name);
        $display("test %0d %s: %s", test_num, name, (errors == err_mark) ? "ok" : "errors seen");
        err_mark = errors;
        test_num++;
    endtask

    // link back-pressure, changes only on the rising edge
    initial begin
        logic [31:0] r;
        daq_ready       = 1'b0;
        daq_almost_full = 1'b0;
        forever begin
            @(posedge clk125);
            case (bp_mode)
                0: begin
                    daq_ready       <= 1'b1;
                    daq_almost_full <= 1'b0;
                end
                1: begin
                    r = $random(seed);
                    daq_ready       <= r[0] | r[1];   // ready about 3 of 4
                    daq_almost_full <= r[2] & r[3];
                end
                default: begin
                    daq_ready       <= 1'b1;
                    daq_almost_full <= 1'b1;
                end
            endcase
        end
    end

    // compares every DAQ word against the head of exp_q
    always @(negedge clk125) begin
        if (ipb_ack) ack_count++;
        if (!daq_ready || daq_almost_full) check_val("daq_valid", daq_valid, 1'b0);
        if (daq_valid) begin
            if (exp_q.size() == 0) begin
                errors++;
                $display("unexpected DAQ word 0x%0h with no event pending", daq_data);
            end else begin
                check_val("daq_data", daq_data, expect_word(exp_q[0], word_pos));
                check_val("daq_header", daq_header, word_pos == 0);
                check_val("daq_trailer", daq_trailer, word_pos == exp_q[0].len + 1);
                word_pos++;
                if (word_pos == exp_q[0].len + 2) begin
                    void'(exp_q.pop_front());
                    word_pos = 0;
                end
            end
        end
    end

    initial begin
        logic [31:0] r;
        int          held;
        int          drops_exp;
        int          n;
        ipb_strobe = 1'b0;
        ipb_addr   = '0;
        ipb_write  = 1'b0;
        ipb_wdata  = '0;
        n = 0;
        while (!rst_n && n < 100) begin
            @(posedge clk125);
            n++;
        end
        if (!rst_n) begin
            errors++;
            $display("timeout: reset never released");
        end

        // register map and reset values
        @(negedge clk125);
        check_val("acq_trigs", acq_trigs, 5'h00);
        check_val("daq_valid", daq_valid, 1'b0);
        reg_expect(`WFD_REG_ID, `WFD_ID_VALUE);
        reg_expect(`WFD_REG_TCOUNT, 32'h0);
        reg_expect(`WFD_REG_DROPS, 32'h0);
        reg_write(`WFD_REG_MASK, 32'hffff_fff5);
        reg_expect(`WFD_REG_MASK, 32'h0000_0015);   // only the low five bits stick
        reg_write(`WFD_REG_LEN, 32'habcd_0003);
        reg_expect(`WFD_REG_LEN, 32'h0000_0003);
        reg_write(`WFD_REG_CTRL, 32'hffff_fffe);
        reg_expect(`WFD_REG_CTRL, 32'h0);
        reg_expect(`WFD_REG_TRIG, 32'h0);
        reg_expect(7, 32'h0);
        reg_expect(24'h123456, 32'h0);
        check_val("ipb_ack count", ack_count, access_count);
        report_test("register access");

        // disabled, so nothing may come out
        fire_trigger(5'h1f, 16'd2, 1'b0, 1'b0);
        check_pulse(5'h00);
        repeat (20) @(posedge clk125);
        reg_expect(`WFD_REG_TCOUNT, 32'h0);
        report_test("trigger while disabled");

        reg_write(`WFD_REG_CTRL, 32'h1);
        reg_expect(`WFD_REG_CTRL, 32'h1);
        fire_trigger(5'b10110, 16'd0, 1'b1, 1'b1);
        check_pulse(5'b10110);
        wait_drain(500);
        report_test("acq_trigs pulse");

        fire_trigger(5'h1f, 16'd0, 1'b1, 1'b1);
        fire_trigger(5'h01, 16'd1, 1'b1, 1'b1);
        fire_trigger(5'h08, 16'd7, 1'b1, 1'b1);
        wait_drain(500);
        reg_expect(`WFD_REG_TCOUNT, 32'(next_num));
        report_test("event format");

        bp_mode <= 1;
        for (int i = 0; i < 6; i++) begin
            @(negedge clk125);
            r = $random(seed);
            fire_trigger(r[4:0], 16'(r[9:8]), 1'b1, 1'b1);
        end
        wait_drain(2000);
        bp_mode <= 0;
        reg_expect(`WFD_REG_DROPS, 32'h0);
        report_test("random back-pressure");

        // builder holds one stalled event, the queue the next DEPTH, the rest drop
        bp_mode <= 2;
        repeat (3) @(posedge clk125);
        held      = 0;
        drops_exp = 0;
        for (int i = 0; i < 6; i++) begin
            if (held < `WFD_FIFO_DEPTH + 1) begin
                fire_trigger(5'h03, 16'd2, 1'b1, 1'b1);
                held++;
            end else begin
                fire_trigger(5'h03, 16'd2, 1'b1, 1'b0);
                drops_exp++;
            end
        end
        reg_expect(`WFD_REG_TCOUNT, 32'(next_num));
        reg_expect(`WFD_REG_DROPS, 32'(drops_exp));
        check_val("queued events", exp_q.size(), held);
        bp_mode <= 0;
        wait_drain(1000);
        check_val("ipb_ack count", ack_count, access_count);
        report_test("queue overflow");

        $display("tests %0d, checks %0d, errors %0d", test_num - 1, checks, errors);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    // last resort if some wait loop is never left
    initial begin
        repeat (50000) @(posedge clk125);
        $display("timeout: run did not complete");
        $display("Simulation FAILED");
        $finish;
    end
endmodule
